//--- procCore.f
src/cpuPkg.sv
src/memArbiter.sv
src/fetchUnit.sv
src/dataUnit.sv
src/controlUnit.sv
src/procCore.sv
testbench/procCore_assert.sv
testbench/procCoreTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the procCore testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module procCoreTb \
	-f procCore.f

./obj_dir/VprocCoreTb | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
else
	exit 1
fi

//--- src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
	input logic clk,
	input logic arstN,
	input memWord_u instr,
	input logic fetchDone,
	input logic dataDone,
	input logic accZero,
	output logic startFetch,
	output logic loadPc,
	output logic incPc,
	output logic startLoad,
	output logic startStore,
	output logic doAdd,
	output logic doInc,
	output logic doRst,
	output logic [AddrWidth-1:0] operandAddr,
	output logic halted
);

	logic [StateWidth-1:0] state;
	logic [OpWidth-1:0] opcode;
	logic haltOp;
	logic memOp;

	assign opcode = instr.insn.opcode;
	assign operandAddr = instr.insn.operand;

	// Codes past OpJmpz are not assigned and stop the program like OpEnd.
	assign haltOp = (opcode == OpEnd) || (opcode > OpJmpz);
	assign memOp = (opcode == OpLdAc) || (opcode == OpStAc) || (opcode == OpAdd);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= StFetch;
			startFetch <= 1'b0;
			loadPc <= 1'b0;
			incPc <= 1'b0;
			startLoad <= 1'b0;
			startStore <= 1'b0;
			doAdd <= 1'b0;
			doInc <= 1'b0;
			doRst <= 1'b0;
			halted <= 1'b0;
		end else begin
			// Commands are single-cycle pulses.
			startFetch <= 1'b0;
			loadPc <= 1'b0;
			incPc <= 1'b0;
			startLoad <= 1'b0;
			startStore <= 1'b0;
			doAdd <= 1'b0;
			doInc <= 1'b0;
			doRst <= 1'b0;

			case (state)
				StFetch: begin
					startFetch <= 1'b1;
					state <= StWaitFetch;
				end
				StWaitFetch: begin
					if (fetchDone && haltOp) begin
						halted <= 1'b1;
						state <= StHalt;
					end else if (fetchDone) begin
						state <= StExecute;
						case (opcode)
							OpLdAc: startLoad <= 1'b1;
							OpStAc: startStore <= 1'b1;
							OpAdd: doAdd <= 1'b1;
							OpIncAc: begin
								doInc <= 1'b1;
								incPc <= 1'b1;
							end
							OpRstAc: begin
								doRst <= 1'b1;
								incPc <= 1'b1;
							end
							OpJmp: loadPc <= 1'b1;
							OpJmpz: begin
								loadPc <= accZero;
								incPc <= !accZero;
							end
							default: ;
						endcase
					end
				end
				StExecute: begin
					// The PC settles at the end of this cycle, before the next fetch reads it.
					if (memOp) begin
						state <= StWaitData;
					end else begin
						startFetch <= 1'b1;
						state <= StWaitFetch;
					end
				end
				StWaitData: begin
					if (dataDone) begin
						incPc <= 1'b1;
						state <= StFetch;
					end
				end
				StHalt: state <= StHalt;
				default: state <= StFetch;
			endcase
		end
	end

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

	localparam int WordWidth = 16;
	localparam int AddrWidth = 12;
	localparam int OpWidth = 4;

	// Credits granted by the memory out of reset, equal to its request queue depth.
	localparam int MemCredits = 2;
	localparam int CreditWidth = $clog2(MemCredits + 1);
	localparam int OwnerPtrWidth = (MemCredits > 1) ? $clog2(MemCredits) : 1;

	localparam logic [OpWidth-1:0] OpEnd = 4'd0;
	localparam logic [OpWidth-1:0] OpLdAc = 4'd1;
	localparam logic [OpWidth-1:0] OpStAc = 4'd2;
	localparam logic [OpWidth-1:0] OpAdd = 4'd3;
	localparam logic [OpWidth-1:0] OpIncAc = 4'd4;
	localparam logic [OpWidth-1:0] OpRstAc = 4'd5;
	localparam logic [OpWidth-1:0] OpJmp = 4'd6;
	localparam logic [OpWidth-1:0] OpJmpz = 4'd7;

	// Owner of an outstanding read.
	localparam logic ReqFetch = 1'b0;
	localparam logic ReqData = 1'b1;

	localparam int StateWidth = 3;
	localparam logic [StateWidth-1:0] StFetch = 3'd0;
	localparam logic [StateWidth-1:0] StWaitFetch = 3'd1;
	localparam logic [StateWidth-1:0] StExecute = 3'd2;
	localparam logic [StateWidth-1:0] StWaitData = 3'd3;
	localparam logic [StateWidth-1:0] StHalt = 3'd4;

	// One memory word, read either as an instruction or as a data value.
	typedef union packed {
		struct packed {
			logic [OpWidth-1:0] opcode;
			logic [AddrWidth-1:0] operand;
		} insn;
		logic signed [WordWidth-1:0] data;
	} memWord_u;

endpackage

//--- src/dataUnit.sv
`timescale 1ns/1ps

module dataUnit import cpuPkg::*; (
	input logic clk,
	input logic arstN,
	input logic startLoad,
	input logic startStore,
	input logic doAdd,
	input logic doInc,
	input logic doRst,
	input logic [AddrWidth-1:0] operandAddr,
	input logic dataGnt,
	input logic dataRsp,
	input memWord_u rspData,
	output logic dataReq,
	output logic dataWrite,
	output logic [AddrWidth-1:0] dataAddr,
	output logic [WordWidth-1:0] dataWdata,
	output logic dataDone,
	output logic [WordWidth-1:0] acc,
	output logic accZero
);

	logic addMode;
	logic startAccess;

	assign startAccess = startLoad || startStore || doAdd;
	assign dataWdata = acc;
	assign accZero = (acc == '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			acc <= '0;
			dataReq <= 1'b0;
			dataWrite <= 1'b0;
			addMode <= 1'b0;
			dataDone <= 1'b0;
		end else begin
			if (startAccess) begin
				dataReq <= 1'b1;
				dataWrite <= startStore;
				addMode <= doAdd;
			end else if (dataGnt) begin
				dataReq <= 1'b0;
			end

			// A store is finished once granted, a read once its data is back.
			dataDone <= dataRsp || (dataGnt && dataWrite);

			// The sum wraps at the word width.
			if (dataRsp) begin
				acc <= addMode ? acc + rspData.data : rspData.data;
			end else if (doRst) begin
				acc <= '0;
			end else if (doInc) begin
				acc <= acc + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (startAccess) begin
			dataAddr <= operandAddr;
		end
	end

endmodule

//--- src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; (
	input logic clk,
	input logic arstN,
	input logic startFetch,
	input logic loadPc,
	input logic incPc,
	input logic [AddrWidth-1:0] jumpAddr,
	input logic fetchGnt,
	input logic fetchRsp,
	input logic [WordWidth-1:0] rspData,
	output logic fetchReq,
	output logic [AddrWidth-1:0] fetchAddr,
	output logic fetchDone,
	output memWord_u instr
);

	logic [AddrWidth-1:0] pc;

	assign fetchAddr = pc;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			fetchReq <= 1'b0;
			fetchDone <= 1'b0;
		end else begin
			if (loadPc) begin
				pc <= jumpAddr;
			end else if (incPc) begin
				pc <= pc + 1'b1;
			end

			// The request is held until the arbiter grants it.
			if (startFetch) begin
				fetchReq <= 1'b1;
			end else if (fetchGnt) begin
				fetchReq <= 1'b0;
			end

			fetchDone <= fetchRsp;
		end
	end

	// The instruction register is valid in the cycle fetchDone is high.
	always_ff @(posedge clk) begin
		if (fetchRsp) begin
			instr <= rspData;
		end
	end

endmodule

//--- src/memArbiter.sv
`timescale 1ns/1ps

module memArbiter import cpuPkg::*; (
	input logic clk,
	input logic arstN,
	input logic fetchReq,
	input logic [AddrWidth-1:0] fetchAddr,
	output logic fetchGnt,
	output logic fetchRsp,
	input logic dataReq,
	input logic dataWrite,
	input logic [AddrWidth-1:0] dataAddr,
	input logic [WordWidth-1:0] dataWdata,
	output logic dataGnt,
	output logic dataRsp,
	output logic [WordWidth-1:0] rspData,
	output logic memReqValid,
	output logic memReqWrite,
	output logic [AddrWidth-1:0] memReqAddr,
	output logic [WordWidth-1:0] memReqData,
	input logic memCredit,
	input logic memRspValid,
	input logic [WordWidth-1:0] memRspData
);

	logic [CreditWidth-1:0] creditCnt;
	logic [CreditWidth-1:0] ownerCnt;
	logic ownerQ [MemCredits];
	logic [OwnerPtrWidth-1:0] wrPtr;
	logic [OwnerPtrWidth-1:0] rdPtr;
	logic haveCredit;
	logic ownerFull;
	logic readIssue;

	function automatic logic [OwnerPtrWidth-1:0] stepPtr(input logic [OwnerPtrWidth-1:0] ptr);
		if (ptr == OwnerPtrWidth'(MemCredits - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign haveCredit = (creditCnt != '0);
	assign ownerFull = (ownerCnt == CreditWidth'(MemCredits));

	// The data unit wins. A read also needs a free slot in the owner queue.
	assign dataGnt = dataReq && haveCredit && (dataWrite || !ownerFull);
	assign fetchGnt = fetchReq && !dataReq && haveCredit && !ownerFull;

	assign memReqValid = dataGnt || fetchGnt;
	assign memReqWrite = dataGnt && dataWrite;
	assign memReqAddr = dataGnt ? dataAddr : fetchAddr;
	assign memReqData = dataWdata;
	assign readIssue = memReqValid && !memReqWrite;

	// Responses come back in order, so the oldest queued owner takes them.
	assign fetchRsp = memRspValid && (ownerQ[rdPtr] == ReqFetch);
	assign dataRsp = memRspValid && (ownerQ[rdPtr] == ReqData);
	assign rspData = memRspData;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			creditCnt <= CreditWidth'(MemCredits);
		end else begin
			case ({memReqValid, memCredit})
				2'b10: creditCnt <= creditCnt - 1'b1;
				2'b01: creditCnt <= creditCnt + 1'b1;
				default: creditCnt <= creditCnt;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			ownerCnt <= '0;
		end else begin
			if (readIssue) begin
				wrPtr <= stepPtr(wrPtr);
			end
			if (memRspValid) begin
				rdPtr <= stepPtr(rdPtr);
			end
			ownerCnt <= ownerCnt + CreditWidth'(readIssue) - CreditWidth'(memRspValid);
		end
	end

	always_ff @(posedge clk) begin
		if (readIssue) begin
			ownerQ[wrPtr] <= dataGnt ? ReqData : ReqFetch;
		end
	end

endmodule

//--- src/procCore.sv
`timescale 1ns/1ps

module procCore import cpuPkg::*; (
	input logic clk,
	input logic arstN,
	output logic memReqValid,
	output logic memReqWrite,
	output logic [AddrWidth-1:0] memReqAddr,
	output logic [WordWidth-1:0] memReqData,
	input logic memCredit,
	input logic memRspValid,
	input logic [WordWidth-1:0] memRspData,
	output logic halted,
	output logic [WordWidth-1:0] acc
);

	memWord_u instr;
	logic [AddrWidth-1:0] operandAddr;
	logic startFetch, loadPc, incPc, fetchDone;
	logic startLoad, startStore, doAdd, doInc, doRst, dataDone, accZero;
	logic fetchReq, fetchGnt, fetchRsp;
	logic [AddrWidth-1:0] fetchAddr;
	logic dataReq, dataWrite, dataGnt, dataRsp;
	logic [AddrWidth-1:0] dataAddr;
	logic [WordWidth-1:0] dataWdata;
	logic [WordWidth-1:0] rspData;

	controlUnit uControl (
		.clk, .arstN, .instr, .fetchDone, .dataDone, .accZero,
		.startFetch, .loadPc, .incPc, .startLoad, .startStore,
		.doAdd, .doInc, .doRst, .operandAddr, .halted
	);

	fetchUnit uFetch (
		.clk, .arstN, .startFetch, .loadPc, .incPc,
		.jumpAddr(operandAddr), .fetchGnt, .fetchRsp, .rspData,
		.fetchReq, .fetchAddr, .fetchDone, .instr
	);

	dataUnit uData (
		.clk, .arstN, .startLoad, .startStore, .doAdd, .doInc, .doRst,
		.operandAddr, .dataGnt, .dataRsp, .rspData,
		.dataReq, .dataWrite, .dataAddr, .dataWdata, .dataDone, .acc, .accZero
	);

	memArbiter uArbiter (
		.clk, .arstN,
		.fetchReq, .fetchAddr, .fetchGnt, .fetchRsp,
		.dataReq, .dataWrite, .dataAddr, .dataWdata, .dataGnt, .dataRsp,
		.rspData,
		.memReqValid, .memReqWrite, .memReqAddr, .memReqData,
		.memCredit, .memRspValid, .memRspData
	);

endmodule

//--- testbench/procCoreTb.sv
`timescale 1ns/1ps

module procCoreTb import cpuPkg::*; ();

	localparam int VecDepth = 64;
	localparam int CyclesPerWord = 200;
	localparam int MarginCycles = 500;
	localparam int DrainCycles = 20;

	// Record tags in the vector file.
	localparam logic [3:0] TagEnd = 4'h0;
	localparam logic [3:0] TagPreload = 4'h1;
	localparam logic [3:0] TagExpMem = 4'h2;
	localparam logic [3:0] TagExpAcc = 4'h3;

	logic clk;
	logic arstN;
	logic memReqValid;
	logic memReqWrite;
	logic [AddrWidth-1:0] memReqAddr;
	logic [WordWidth-1:0] memReqData;
	logic memCredit;
	logic memRspValid;
	logic [WordWidth-1:0] memRspData;
	logic halted;
	logic [WordWidth-1:0] acc;

	memWord_u mem [1 << AddrWidth];
	logic [31:0] vec [VecDepth];

	// Requests accepted by the memory model and not yet retired.
	logic pendWrite [$];
	logic [AddrWidth-1:0] pendAddr [$];
	logic [WordWidth-1:0] pendData [$];

	logic [AddrWidth-1:0] expAddr [$];
	logic [WordWidth-1:0] expData [$];
	logic [WordWidth-1:0] expAcc;
	logic haveExpAcc;

	logic [31:0] rngState;
	int cycleCount;
	int timeoutLimit;
	int progWords;
	logic haltSeen;

	procCore dut (
		.clk,
		.arstN,
		.memReqValid,
		.memReqWrite,
		.memReqAddr,
		.memReqData,
		.memCredit,
		.memRspValid,
		.memRspData,
		.halted,
		.acc
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic failRun(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
			failRun("value mismatch");
		end
	endtask

	// Credited memory model. Retires at most one request per cycle, oldest first.
	always @(posedge clk) begin : memModel
		logic stall;
		memCredit <= 1'b0;
		memRspValid <= 1'b0;
		if (arstN) begin
			rngState = lcgStep(rngState);
			stall = (rngState[17:16] == 2'b00);
			if (pendAddr.size() > 0 && !stall) begin
				if (pendWrite[0]) begin
					mem[pendAddr[0]] = pendData[0];
				end else begin
					memRspValid <= 1'b1;
					memRspData <= mem[pendAddr[0]].data;
				end
				memCredit <= 1'b1;
				void'(pendWrite.pop_front());
				void'(pendAddr.pop_front());
				void'(pendData.pop_front());
			end
			if (memReqValid) begin
				if (halted) begin
					failRun("a memory request was issued after the halt");
				end else if (pendAddr.size() >= MemCredits) begin
					failRun("more requests outstanding than the memory has credits");
				end else begin
					pendWrite.push_back(memReqWrite);
					pendAddr.push_back(memReqAddr);
					pendData.push_back(memReqData);
				end
			end
		end
	end

	// The halt flag must hold until reset.
	always @(posedge clk) begin
		if (haltSeen && !halted) begin
			failRun("halted dropped after it was raised");
		end else begin
			haltSeen <= halted && arstN;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
			$display("ERROR: the program did not finish within %0d cycles", timeoutLimit);
			failRun("timeout");
		end
	end

	initial begin
		int i;
		logic done;
		logic [3:0] tag;
		logic [AddrWidth-1:0] addr;
		logic [WordWidth-1:0] data;

		arstN = 1'b0;
		memCredit = 1'b0;
		memRspValid = 1'b0;
		memRspData = '0;
		rngState = 32'd34;
		cycleCount = 0;
		timeoutLimit = 0;
		progWords = 0;
		haltSeen = 1'b0;
		haveExpAcc = 1'b0;
		expAcc = '0;

		// Unused words hold a pattern of their own address.
		for (i = 0; i < (1 << AddrWidth); i++) begin
			mem[i] = WordWidth'(i * 16'h0101) ^ 16'h5A3C;
		end
		for (i = 0; i < VecDepth; i++) begin
			vec[i] = '0;
		end
		$readmemh("testbench/procCoreVectors.txt", vec);

		done = 1'b0;
		for (i = 0; i < VecDepth && !done; i++) begin
			tag = vec[i][31:28];
			addr = vec[i][27:16];
			data = vec[i][15:0];
			case (tag)
				TagPreload: begin
					mem[addr] = data;
					progWords++;
				end
				TagExpMem: begin
					expAddr.push_back(addr);
					expData.push_back(data);
				end
				TagExpAcc: begin
					expAcc = data;
					haveExpAcc = 1'b1;
				end
				TagEnd: done = 1'b1;
				default: failRun("the vector file holds a record with an unknown tag");
			endcase
		end
		if (progWords == 0 || !haveExpAcc) begin
			failRun("the vector file holds no program or no expected accumulator");
		end
		timeoutLimit = CyclesPerWord * progWords + MarginCycles;

		repeat (2) @(posedge clk);
		checkEq(32'(memReqValid), 32'd0, "memReqValid during reset");
		checkEq(32'(halted), 32'd0, "halted during reset");
		checkEq(32'(acc), 32'd0, "acc during reset");
		arstN <= 1'b1;
		@(negedge clk);
		checkEq(32'(memReqValid), 32'd0, "memReqValid after reset");
		checkEq(32'(halted), 32'd0, "halted after reset");
		checkEq(32'(acc), 32'd0, "acc after reset");

		while (!halted) begin
			@(posedge clk);
		end
		@(negedge clk);
		checkEq(32'(pendAddr.size()), 32'd0, "requests left in the memory model at the halt");
		repeat (DrainCycles) @(posedge clk);
		@(negedge clk);

		checkEq(32'(halted), 32'd1, "halted after the program end");
		checkEq(32'(acc), 32'(expAcc), "final accumulator");
		for (i = 0; i < expAddr.size(); i++) begin
			checkEq(32'(unsigned'(mem[expAddr[i]].data)), 32'(expData[i]),
				$sformatf("memory word at %h", expAddr[i]));
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- testbench/procCoreVectors.txt
// Each word is TAAADDDD: T tag (1 preload, 2 expected memory, 3 expected acc, 0 end),
// AAA the 12-bit address, DDDD the 16-bit data or instruction word.
10001100
10013101
10022200
10035000
10044000
10054000
10064000
10076009
10084000
10092201
100A700F
100B2202
100C5000
100D7010
100E1101
100F2203
10103102
10112204
10120000
1100FFF0
11010025
11021234
12000000
12010000
12020000
1203DEAD
12040000
22000015
22010003
22020003
2203DEAD
22041234
2100FFF0
30001234
00000000

//--- testbench/procCore_assert.sv
`timescale 1ns/1ps

module procCoreAssert import cpuPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [CreditWidth-1:0] creditCnt,
	input logic [CreditWidth-1:0] ownerCnt,
	input logic memReqValid,
	input logic memCredit,
	input logic memRspValid
);

	// Requests issued whose credit has not come back yet.
	logic [CreditWidth-1:0] inFlight;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			inFlight <= '0;
		end else begin
			inFlight <= inFlight + CreditWidth'(memReqValid) - CreditWidth'(memCredit);
		end
	end

	creditLimit: assert property (@(posedge clk) disable iff (!arstN)
		creditCnt <= CreditWidth'(MemCredits))
		else $error("credit count above the memory credit limit");

	issueNeedsCredit: assert property (@(posedge clk) disable iff (!arstN)
		memReqValid |-> inFlight < CreditWidth'(MemCredits))
		else $error("request issued with no credit left");

	// A response must match a read that is still outstanding.
	rspNeedsRead: assert property (@(posedge clk) disable iff (!arstN)
		memRspValid |-> ownerCnt != '0)
		else $error("response with no read outstanding");

endmodule

bind memArbiter procCoreAssert uCreditAssert (
	.clk,
	.arstN,
	.creditCnt,
	.ownerCnt,
	.memReqValid,
	.memCredit,
	.memRspValid
);
